//--- hw/stream_fifo_pkg.sv
// Shared types for the stream FIFO
// Payload and count widths, the stream beat struct, burst mover states

package stream_fifo_pkg;

  // --------------------
  // Widths with a meaning
  // --------------------

  // One payload word as carried on the streams
  typedef logic [63:0] data_word_t;

  // Occupancy of a beat buffer or of the storage array
  typedef logic [15:0] fill_count_t;

  // --------------------
  // Stream beat
  // --------------------

  // Unit held in both buffers and in the array, 65 bits
  typedef struct packed {
    logic       last;  // End of packet
    data_word_t data;  // Payload
  } stream_beat_t;

  // --------------------
  // Burst mover FSM
  // --------------------

  typedef enum logic [1:0] {
    IDLE,         // Pick the next burst
    WRITE_BURST,  // Ingress buffer to array
    READ_BURST    // Array to egress buffer
  } burst_state_e;

endpackage

//--- hw/axis_beat_buffer.sv
// First-word-fall-through beat buffer with occupancy count
// Used on both the ingress and the egress side

`timescale 1ns/100ps

module axis_beat_buffer
  import stream_fifo_pkg::*;
#(
  parameter int BUF_DEPTH = 16  // Power of two
)
(
  input  logic         bus_clk,
  input  logic         arst_n_i,
  input  stream_beat_t wr_beat_i,
  input  logic         wr_valid_i,
  output logic         wr_ready_o,
  output stream_beat_t rd_beat_o,
  output logic         rd_valid_o,
  input  logic         rd_ready_i,
  output fill_count_t  fill_o
);

  localparam int PTR_W = $clog2(BUF_DEPTH);

  stream_beat_t     mem [BUF_DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  fill_count_t      fill;
  logic             push;
  logic             pop;

  assign wr_ready_o = (fill < fill_count_t'(BUF_DEPTH));  // Room for one more
  assign rd_valid_o = (fill != '0);
  assign rd_beat_o  = mem[rd_ptr];  // Head beat shown without delay
  assign fill_o     = fill;

  assign push = wr_valid_i & wr_ready_o;
  assign pop  = rd_valid_o & rd_ready_i;

  // Storage
  always_ff @(posedge bus_clk)
  begin
    if (push)
      mem[wr_ptr] <= wr_beat_i;
  end

  // --------------------
  // Pointers and count
  // --------------------
  always_ff @(posedge bus_clk or negedge arst_n_i)
  begin
    if (!arst_n_i)
    begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      fill   <= '0;
    end
    else
    begin
      if (push)
        wr_ptr <= wr_ptr + 1'b1;  // Wraps at BUF_DEPTH
      if (pop)
        rd_ptr <= rd_ptr + 1'b1;
      case ({push, pop})
        2'b10:   fill <= fill + 1'b1;
        2'b01:   fill <= fill - 1'b1;
        default: fill <= fill;  // Both or neither leave the count alone
      endcase
    end
  end

endmodule

//--- hw/calib_mem_array.sv
// Single-port beat storage with registered read data
// Calibration counter that holds off traffic after reset

`timescale 1ns/100ps

module calib_mem_array
  import stream_fifo_pkg::*;
#(
  parameter int MEM_AW       = 8,
  parameter int CALIB_CYCLES = 64
)
(
  input  logic              bus_clk,
  input  logic              arst_n_i,
  input  logic              wr_en_i,
  input  logic              rd_en_i,
  input  logic [MEM_AW-1:0] wr_addr_i,
  input  logic [MEM_AW-1:0] rd_addr_i,
  input  stream_beat_t      wr_beat_i,
  output stream_beat_t      rd_beat_o,
  output logic              calib_done_o
);

  localparam int CNT_W = $clog2(CALIB_CYCLES + 1);

  stream_beat_t     mem [2**MEM_AW];
  logic [CNT_W-1:0] calib_cnt;

  // Access is refused until calibration is over
  always_ff @(posedge bus_clk)
  begin
    if (wr_en_i && calib_done_o)
      mem[wr_addr_i] <= wr_beat_i;
    if (rd_en_i && calib_done_o)
      rd_beat_o <= mem[rd_addr_i];  // Valid one cycle after the strobe
  end

  // --------------------
  // Calibration
  // --------------------
  always_ff @(posedge bus_clk or negedge arst_n_i)
  begin
    if (!arst_n_i)
    begin
      calib_cnt    <= '0;
      calib_done_o <= 1'b0;
    end
    else if (!calib_done_o)
    begin
      calib_cnt <= calib_cnt + 1'b1;
      // Done on the CALIB_CYCLES-th edge after release, then sticky
      if (calib_cnt == CNT_W'(CALIB_CYCLES - 1))
        calib_done_o <= 1'b1;
    end
  end

endmodule

//--- hw/burst_mover.sv
// Burst mover between the beat buffers and the storage array
// FSM, ring pointers and fill level of the array

`timescale 1ns/100ps

module burst_mover
  import stream_fifo_pkg::*;
#(
  parameter int BUF_DEPTH = 16,
  parameter int MEM_AW    = 8,
  parameter int BURST_LEN = 8
)
(
  input  logic              bus_clk,
  input  logic              arst_n_i,
  input  logic              calib_done_i,
  input  stream_beat_t      in_beat_i,      // Ingress buffer head
  input  logic              in_valid_i,
  output logic              in_ready_o,
  input  fill_count_t       in_fill_i,
  output stream_beat_t      out_beat_o,     // Egress buffer push side
  output logic              out_valid_o,
  input  logic              out_ready_i,
  input  fill_count_t       out_fill_i,
  output logic              mem_wr_en_o,
  output logic              mem_rd_en_o,
  output logic [MEM_AW-1:0] mem_wr_addr_o,
  output logic [MEM_AW-1:0] mem_rd_addr_o,
  output stream_beat_t      mem_wr_beat_o,
  input  stream_beat_t      mem_rd_beat_i
);

  localparam fill_count_t MEM_WORDS = fill_count_t'(2**MEM_AW);

  burst_state_e      state;
  logic [MEM_AW-1:0] wr_ptr;
  logic [MEM_AW-1:0] rd_ptr;
  fill_count_t       mem_fill;    // Words held in the array
  fill_count_t       beats_left;  // Beats still to move in this burst
  logic              rd_pend;     // Read data arrives this cycle
  fill_count_t       mem_free;
  fill_count_t       out_free;
  fill_count_t       wr_len;
  fill_count_t       rd_len;
  logic              wr_fire;
  logic              rd_go;
  logic              wr_go;

  function automatic fill_count_t min3(fill_count_t a, fill_count_t b, fill_count_t c);
    fill_count_t m;
    m = (a < b) ? a : b;
    return (m < c) ? m : c;
  endfunction

  assign mem_free = MEM_WORDS - mem_fill;
  // Count the beat still in flight from the array as taken
  assign out_free = fill_count_t'(BUF_DEPTH) - out_fill_i - fill_count_t'(rd_pend);
  assign wr_len   = min3(fill_count_t'(BURST_LEN), in_fill_i, mem_free);
  assign rd_len   = min3(fill_count_t'(BURST_LEN), mem_fill, out_free);

  assign rd_go = calib_done_i && (mem_fill != '0) && (out_free != '0) && out_ready_i;
  assign wr_go = calib_done_i && (in_fill_i != '0) && (mem_free != '0);

  // --------------------
  // Array and buffer strobes
  // --------------------
  assign in_ready_o    = (state == WRITE_BURST);
  assign wr_fire       = in_valid_i & in_ready_o;
  assign mem_wr_en_o   = wr_fire;
  assign mem_wr_addr_o = wr_ptr;
  assign mem_wr_beat_o = in_beat_i;
  assign mem_rd_en_o   = (state == READ_BURST);
  assign mem_rd_addr_o = rd_ptr;
  assign out_beat_o    = mem_rd_beat_i;
  assign out_valid_o   = rd_pend;

  always_ff @(posedge bus_clk or negedge arst_n_i)
  begin
    if (!arst_n_i)
    begin
      state      <= IDLE;
      wr_ptr     <= '0;
      rd_ptr     <= '0;
      mem_fill   <= '0;
      beats_left <= '0;
      rd_pend    <= 1'b0;
    end
    else
    begin
      rd_pend <= mem_rd_en_o;
      case (state)
        IDLE:
        begin
          if (rd_go)  // Reads first to keep the output moving
          begin
            state      <= READ_BURST;
            beats_left <= rd_len;
          end
          else if (wr_go)
          begin
            state      <= WRITE_BURST;
            beats_left <= wr_len;
          end
        end
        WRITE_BURST:
        begin
          if (wr_fire)
          begin
            beats_left <= beats_left - 1'b1;
            if (beats_left == fill_count_t'(1))
              state <= IDLE;
          end
        end
        default:  // READ_BURST, one strobe per cycle
        begin
          beats_left <= beats_left - 1'b1;
          if (beats_left == fill_count_t'(1))
            state <= IDLE;
        end
      endcase
      if (wr_fire)
        wr_ptr <= wr_ptr + 1'b1;  // Ring wraps at 2**MEM_AW
      if (mem_rd_en_o)
        rd_ptr <= rd_ptr + 1'b1;
      if (wr_fire)
        mem_fill <= mem_fill + 1'b1;  // Never both in one cycle
      else if (mem_rd_en_o)
        mem_fill <= mem_fill - 1'b1;
    end
  end

endmodule

//--- hw/axis_dram_fifo_single.sv
// Top level of the stream FIFO with deep storage
// Ingress buffer, burst mover, storage array, egress buffer

`timescale 1ns/100ps

module axis_dram_fifo_single
  import stream_fifo_pkg::*;
#(
  parameter int BUF_DEPTH    = 16,
  parameter int MEM_AW       = 8,
  parameter int BURST_LEN    = 8,
  parameter int CALIB_CYCLES = 64
)
(
  input  logic       bus_clk,
  input  logic       arst_n_i,
  input  data_word_t i_tdata_i,
  input  logic       i_tlast_i,
  input  logic       i_tvalid_i,
  output logic       i_tready_o,
  output data_word_t o_tdata_o,
  output logic       o_tlast_o,
  output logic       o_tvalid_o,
  input  logic       o_tready_i,
  output logic       init_calib_complete_o
);

  stream_beat_t      in_beat;
  stream_beat_t      in_head;
  stream_beat_t      out_push;
  stream_beat_t      out_head;
  stream_beat_t      mem_wr_beat;
  stream_beat_t      mem_rd_beat;
  logic              in_wr_valid;
  logic              in_wr_ready;
  logic              in_rd_valid;
  logic              in_rd_ready;
  logic              out_wr_valid;
  logic              out_wr_ready;
  fill_count_t       in_fill;
  fill_count_t       out_fill;
  logic              mem_wr_en;
  logic              mem_rd_en;
  logic [MEM_AW-1:0] mem_wr_addr;
  logic [MEM_AW-1:0] mem_rd_addr;
  logic              calib_done;

  // Input stream is shut until the array is calibrated
  assign in_beat     = '{last: i_tlast_i, data: i_tdata_i};
  assign in_wr_valid = i_tvalid_i & calib_done;
  assign i_tready_o  = in_wr_ready & calib_done;

  assign o_tdata_o             = out_head.data;
  assign o_tlast_o             = out_head.last;
  assign init_calib_complete_o = calib_done;

  axis_beat_buffer #(.BUF_DEPTH(BUF_DEPTH)) ingress_buf (
    .bus_clk, .arst_n_i,
    .wr_beat_i(in_beat), .wr_valid_i(in_wr_valid), .wr_ready_o(in_wr_ready),
    .rd_beat_o(in_head), .rd_valid_o(in_rd_valid), .rd_ready_i(in_rd_ready),
    .fill_o(in_fill)
  );

  burst_mover #(.BUF_DEPTH(BUF_DEPTH), .MEM_AW(MEM_AW), .BURST_LEN(BURST_LEN)) mover (
    .bus_clk, .arst_n_i, .calib_done_i(calib_done),
    .in_beat_i(in_head), .in_valid_i(in_rd_valid), .in_ready_o(in_rd_ready),
    .in_fill_i(in_fill),
    .out_beat_o(out_push), .out_valid_o(out_wr_valid), .out_ready_i(out_wr_ready),
    .out_fill_i(out_fill),
    .mem_wr_en_o(mem_wr_en), .mem_rd_en_o(mem_rd_en),
    .mem_wr_addr_o(mem_wr_addr), .mem_rd_addr_o(mem_rd_addr),
    .mem_wr_beat_o(mem_wr_beat), .mem_rd_beat_i(mem_rd_beat)
  );

  calib_mem_array #(.MEM_AW(MEM_AW), .CALIB_CYCLES(CALIB_CYCLES)) mem_array (
    .bus_clk, .arst_n_i,
    .wr_en_i(mem_wr_en), .rd_en_i(mem_rd_en),
    .wr_addr_i(mem_wr_addr), .rd_addr_i(mem_rd_addr),
    .wr_beat_i(mem_wr_beat), .rd_beat_o(mem_rd_beat),
    .calib_done_o(calib_done)
  );

  axis_beat_buffer #(.BUF_DEPTH(BUF_DEPTH)) egress_buf (
    .bus_clk, .arst_n_i,
    .wr_beat_i(out_push), .wr_valid_i(out_wr_valid), .wr_ready_o(out_wr_ready),
    .rd_beat_o(out_head), .rd_valid_o(o_tvalid_o), .rd_ready_i(o_tready_i),
    .fill_o(out_fill)
  );

endmodule

//--- verif/dram_fifo_properties.sv
// Bound checker for the stream FIFO top level
// Output ordering, output handshake and calibration rules

`timescale 1ns/100ps

module dram_fifo_properties
  import stream_fifo_pkg::*;
(
  input logic       bus_clk,
  input logic       arst_n_i,
  input logic       i_tready_o,
  input data_word_t o_tdata_o,
  input logic       o_tlast_o,
  input logic       o_tvalid_o,
  input logic       o_tready_i,
  input logic       init_calib_complete_o
);

  data_word_t out_idx;  // Index of the next beat due at the output
  int         fail_count = 0;

  always_ff @(posedge bus_clk or negedge arst_n_i)
  begin
    if (!arst_n_i)
      out_idx <= '0;
    else if (o_tvalid_o && o_tready_i)
      out_idx <= out_idx + 1'b1;
  end

  // --------------------
  // Ordering
  // --------------------
  a_out_data: assert property (@(posedge bus_clk) disable iff (!arst_n_i)
    o_tvalid_o |-> o_tdata_o == out_idx)
    else begin fail_count++; $error("Output word out of order"); end

  a_out_last: assert property (@(posedge bus_clk) disable iff (!arst_n_i)
    o_tvalid_o |-> o_tlast_o == (out_idx[3:0] == 4'hf))
    else begin fail_count++; $error("Output last flag wrong"); end

  a_out_hold: assert property (@(posedge bus_clk) disable iff (!arst_n_i)
    o_tvalid_o && !o_tready_i |=> o_tvalid_o && $stable(o_tdata_o) && $stable(o_tlast_o))
    else begin fail_count++; $error("Output beat dropped or changed before taken"); end

  // --------------------
  // Calibration
  // --------------------
  a_no_ready_early: assert property (@(posedge bus_clk) disable iff (!arst_n_i)
    !init_calib_complete_o |-> !i_tready_o)
    else begin fail_count++; $error("Input ready before calibration"); end

  a_calib_sticky: assert property (@(posedge bus_clk) disable iff (!arst_n_i)
    init_calib_complete_o |=> init_calib_complete_o)
    else begin fail_count++; $error("Calibration done fell"); end

endmodule

bind axis_dram_fifo_single dram_fifo_properties props (
  .bus_clk(bus_clk), .arst_n_i(arst_n_i), .i_tready_o(i_tready_o),
  .o_tdata_o(o_tdata_o), .o_tlast_o(o_tlast_o), .o_tvalid_o(o_tvalid_o),
  .o_tready_i(o_tready_i), .init_calib_complete_o(init_calib_complete_o)
);

//--- verif/dram_fifo_tb.sv
// Testbench for the stream FIFO with deep storage
// Clock, reset, stream drivers, test phases, watchdog and end-of-run report

`timescale 1ns/100ps

module dram_fifo_tb;
  import stream_fifo_pkg::*;

  localparam int BUF_DEPTH    = 16;
  localparam int MEM_AW       = 8;
  localparam int BURST_LEN    = 8;
  localparam int CALIB_CYCLES = 64;
  localparam int CAPACITY     = 2 * BUF_DEPTH + 2**MEM_AW;
  localparam int STREAM_BEATS = 1000;
  // Phase lengths in cycles for two calibrations, short packets, capacity run and random stream
  localparam int RUN_CYCLES   = 2 * (CALIB_CYCLES + 40) + 400 + 4 * CAPACITY + 100
                                + 8 * STREAM_BEATS;

  logic       bus_clk;
  logic       arst_n;
  data_word_t i_tdata;
  logic       i_tlast;
  logic       i_tvalid;
  logic       i_tready;
  data_word_t o_tdata;
  logic       o_tlast;
  logic       o_tvalid;
  logic       o_tready;
  logic       calib_done;

  integer      seed = 32'h83020f16;
  int          errors = 0;
  int          in_count;      // Accepted input beats since reset
  int          out_count;     // Delivered output beats since reset
  int          in_limit = 0;  // Input stops offering at this index
  int          in_mode = 0;   // 0 idle, 1 always valid, 2 random valid
  int          out_mode = 0;  // 0 stalled, 1 always ready, 2 random ready
  int          idle_run;
  int          accepted;

  axis_dram_fifo_single #(
    .BUF_DEPTH(BUF_DEPTH), .MEM_AW(MEM_AW), .BURST_LEN(BURST_LEN),
    .CALIB_CYCLES(CALIB_CYCLES)
  ) dut0 (
    .bus_clk, .arst_n_i(arst_n),
    .i_tdata_i(i_tdata), .i_tlast_i(i_tlast), .i_tvalid_i(i_tvalid), .i_tready_o(i_tready),
    .o_tdata_o(o_tdata), .o_tlast_o(o_tlast), .o_tvalid_o(o_tvalid), .o_tready_i(o_tready),
    .init_calib_complete_o(calib_done)
  );

  initial
  begin
    bus_clk = 1'b0;
    forever #4 bus_clk = ~bus_clk;
  end

  // --------------------
  // Stream drivers
  // --------------------
  always @(posedge bus_clk)
  begin
    int nxt;
    int r;
    r = $random(seed);  // Bit 0 for input valid, bit 1 for output ready
    nxt = in_count;
    if (i_tvalid && i_tready)
      nxt = nxt + 1;
    if (!arst_n)
      nxt = 0;  // Index restarts after every reset
    in_count <= nxt;
    if (!(arst_n && i_tvalid && !i_tready))  // Offered beat holds until taken
    begin
      i_tvalid <= (nxt < in_limit) && (in_mode == 1 || (in_mode == 2 && r[0]));
      i_tdata  <= data_word_t'(nxt);
      i_tlast  <= (nxt[3:0] == 4'hf);
    end
    if (!arst_n)
      out_count <= 0;
    else if (o_tvalid && o_tready)
      out_count <= out_count + 1;
    o_tready <= (out_mode == 1) || (out_mode == 2 && r[1]);
  end

  // Counts cycles from reset release to calibration done
  task automatic check_calib();
    int cyc;
    cyc = 0;
    while (!calib_done && cyc < 4 * CALIB_CYCLES)
    begin
      @(posedge bus_clk);
      cyc++;
      assert (calib_done || !i_tready) else
      begin
        errors++;
        $display("FAILED at %0t: input ready high before calibration", $time);
      end
    end
    // Sampled values lag one edge behind the rise
    assert (cyc - 1 == CALIB_CYCLES) else
    begin
      errors++;
      $display("FAILED at %0t: calibration took %0d cycles", $time, cyc - 1);
    end
  endtask

  // Lets the output run until every accepted beat has come out
  task automatic drain_all(int max_cycles);
    int cyc;
    cyc = 0;
    out_mode = 1;
    while ((out_count != in_count || i_tvalid) && cyc < max_cycles)
    begin
      @(posedge bus_clk);
      cyc++;
    end
    assert (out_count == in_count) else
    begin
      errors++;
      $display("FAILED at %0t: %0d beats in, %0d out", $time, in_count, out_count);
    end
  endtask

  initial
  begin
    arst_n   = 1'b0;
    i_tvalid = 1'b0;
    i_tdata  = '0;
    i_tlast  = 1'b0;
    o_tready = 1'b0;
    repeat (2) @(posedge bus_clk);
    arst_n <= 1'b1;

    // Calibration with valid input offered, then a short packet
    in_limit = 16;
    in_mode  = 1;
    check_calib();
    while (in_count < 16)
      @(posedge bus_clk);
    repeat (20) @(posedge bus_clk);
    drain_all(500);

    // Full capacity with the output stalled
    out_mode = 0;
    in_limit = 1 << 30;
    idle_run = 0;
    while (idle_run < 100)
    begin
      @(posedge bus_clk);
      idle_run = i_tready ? 0 : idle_run + 1;
    end
    accepted = in_count - 16;
    assert (accepted == CAPACITY) else
    begin
      errors++;
      $display("FAILED at %0t: capacity %0d, expected %0d", $time, accepted, CAPACITY);
    end
    in_mode = 0;
    drain_all(8 * CAPACITY);

    // Random valid and ready
    in_limit = in_count + STREAM_BEATS;
    in_mode  = 2;
    out_mode = 2;
    while (in_count < in_limit)
      @(posedge bus_clk);
    drain_all(4 * CAPACITY);

    // Reset in the middle of traffic
    in_limit = 1 << 30;
    out_mode = 2;
    repeat (50) @(posedge bus_clk);
    arst_n <= 1'b0;
    @(posedge bus_clk);
    @(posedge bus_clk);
    assert (!o_tvalid && !i_tready && !calib_done) else
    begin
      errors++;
      $display("FAILED at %0t: outputs not cleared by reset", $time);
    end
    in_limit = 16;
    in_mode  = 1;
    out_mode = 0;
    arst_n <= 1'b1;
    check_calib();
    while (in_count < 16)
      @(posedge bus_clk);
    drain_all(500);

    $display("Errors: testbench %0d, assertions %0d", errors, dut0.props.fail_count);
    if (errors == 0 && dut0.props.fail_count == 0)
      $display("Simulation completed successfully");
    else
      $display("Simulation failed");
    $finish;
  end

  // Watchdog
  initial
  begin
    repeat (2 * RUN_CYCLES) @(posedge bus_clk);
    $display("Timeout: the test phases did not finish in time");
    $display("Simulation failed");
    $finish;
  end

endmodule

//--- run_sim.sh
#!/usr/bin/env bash
# Builds and runs the stream FIFO testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert \
  --top-module dram_fifo_tb \
  -f project.f \
  -o Vdram_fifo_tb
if [ $? -ne 0 ]; then
  echo "Build failed"
  exit 1
fi

./obj_dir/Vdram_fifo_tb +verilator+error+limit+1000 > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulator exited with status $status"
  exit 1
fi

if grep -q "Simulation failed" "$LOG"; then
  exit 1
fi
if ! grep -q "Simulation completed successfully" "$LOG"; then
  echo "No result line in $LOG"
  exit 1
fi
exit 0

//--- project.f
hw/stream_fifo_pkg.sv
hw/axis_beat_buffer.sv
hw/calib_mem_array.sv
hw/burst_mover.sv
hw/axis_dram_fifo_single.sv
verif/dram_fifo_properties.sv
verif/dram_fifo_tb.sv
